/* src/apb_periph_defines.svh */
/*
 * APB peripheral subsystem parameters
 * Bus widths, address map, register offsets and the SoC identifier
 */
`ifndef APB_PERIPH_DEFINES_SVH
`define APB_PERIPH_DEFINES_SVH

`define APB_AW 32
`define APB_DW 32

// One 4 KiB window per slave
`define NUM_SLAVES  3
`define SLV_SEL_LSB 12
`define SLV_SEL_MSB 15
`define REG_OFF_LSB 2
`define REG_OFF_MSB 5

`define NUM_GPIO     16
`define PWM_CH       4
`define PWM_CW       16
`define SOC_ID_VALUE 32'h50C0_0A01

// Word offsets inside each window
`define GPIO_OUT    4'h0
`define GPIO_DIR    4'h1
`define GPIO_IN     4'h2
`define PWM_CTRL    4'h0
`define PWM_PERIOD  4'h1
`define PWM_CMP0    4'h2
`define PWM_CMP1    4'h3
`define PWM_CMP2    4'h4
`define PWM_CMP3    4'h5
`define SOC_CLUSTER 4'h0
`define SOC_ID      4'h1

`endif

/* src/apb_periph_pkg.sv */
/*
 * APB peripheral subsystem types
 * Bus request and response structs plus the pad and cluster control bundles
 */
`include "apb_periph_defines.svh"

package apb_periph_pkg;

   typedef logic [`APB_AW-1:0]                  apb_addr_t;
   typedef logic [`APB_DW-1:0]                  apb_data_t;
   typedef logic [`REG_OFF_MSB-`REG_OFF_LSB:0]  reg_off_t;

   // Requester side of an APB transfer
   typedef struct packed {
      logic       psel;
      logic       penable;
      logic       pwrite;
      apb_addr_t  paddr;
      apb_data_t  pwdata;
   } apb_req_t;

   // Completer side
   typedef struct packed {
      apb_data_t  prdata;
      logic       pready;
      logic       pslverr;
   } apb_rsp_t;

   typedef struct packed {
      logic [`NUM_GPIO-1:0] out;
      logic [`NUM_GPIO-1:0] oe;
   } gpio_pads_t;

   // Field order matches the SOC_CLUSTER register bits [2:0]
   typedef struct packed {
      logic fetch_en;
      logic boot_en;
      logic cluster_rstn;
   } cluster_ctrl_t;

endpackage

/* src/apb_periph_decoder.sv */
/*
 * APB address decoder
 * Routes each transfer to the slave picked by the window bits and
 * returns its response, or an error for an unmapped window
 */
`include "apb_periph_defines.svh"

module apb_periph_decoder (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  apb_periph_pkg::apb_req_t  slv_req_i,
   output apb_periph_pkg::apb_rsp_t  slv_rsp_o,
   output apb_periph_pkg::apb_req_t  mst_req_o [`NUM_SLAVES],
   input  apb_periph_pkg::apb_rsp_t  mst_rsp_i [`NUM_SLAVES]
);

   logic [`SLV_SEL_MSB-`SLV_SEL_LSB:0] win;
   logic [`NUM_SLAVES-1:0]             sel;
   logic [`NUM_SLAVES-1:0]             mst_psel;
   logic                               mapped;
   logic                               access;

   assign win    = slv_req_i.paddr[`SLV_SEL_MSB:`SLV_SEL_LSB];
   assign mapped = |sel;
   assign access = slv_req_i.psel && slv_req_i.penable;

   // Fan the request out, only the hit slave sees psel and penable
   always_comb begin
      for (int i = 0; i < `NUM_SLAVES; i++) begin
         sel[i]               = (win == i);
         mst_req_o[i]         = slv_req_i;
         mst_req_o[i].psel    = slv_req_i.psel && sel[i];
         mst_req_o[i].penable = slv_req_i.penable && sel[i];
         mst_psel[i]          = mst_req_o[i].psel;
      end
   end

   always_comb begin
      // Unmapped window answers at once with an error and zero data
      slv_rsp_o.prdata  = '0;
      slv_rsp_o.pready  = access;
      slv_rsp_o.pslverr = access && !mapped;
      for (int i = 0; i < `NUM_SLAVES; i++) begin
         if (sel[i]) begin
            slv_rsp_o = mst_rsp_i[i];
         end
      end
   end

   a_psel_onehot: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(mst_psel)
   ) else $error("more than one APB slave selected");

   // Requester must hold the transfer until it completes
   a_req_stable: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      slv_req_i.psel && !(slv_req_i.penable && slv_rsp_o.pready)
      |=> slv_req_i.psel
          && $stable(slv_req_i.paddr)
          && $stable(slv_req_i.pwrite)
          && $stable(slv_req_i.pwdata)
   ) else $error("APB request changed before completion");

endmodule

/* src/apb_gpio.sv */
/*
 * APB GPIO block
 * Output value and direction registers plus a two-stage
 * synchronizer on the raw pin inputs
 */
`include "apb_periph_defines.svh"

module apb_gpio (
   input  logic                        clk_i,
   input  logic                        rst_n_i,
   input  apb_periph_pkg::apb_req_t    req_i,
   output apb_periph_pkg::apb_rsp_t    rsp_o,
   input  logic [`NUM_GPIO-1:0]        gpio_in_i,
   output apb_periph_pkg::gpio_pads_t  gpio_pads_o
);
   import apb_periph_pkg::*;

   reg_off_t             reg_off;
   logic                 access;
   logic                 wr_en;
   logic [`NUM_GPIO-1:0] out_q;
   logic [`NUM_GPIO-1:0] dir_q;
   logic [`NUM_GPIO-1:0] sync1_q;
   logic [`NUM_GPIO-1:0] sync2_q;

   assign reg_off = req_i.paddr[`REG_OFF_MSB:`REG_OFF_LSB];
   assign access  = req_i.psel && req_i.penable;
   assign wr_en   = access && req_i.pwrite;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         out_q <= '0;
         dir_q <= '0;
      end else if (wr_en) begin
         // GPIO_IN is read only, writes there are dropped
         if (reg_off == `GPIO_OUT) begin
            out_q <= req_i.pwdata[`NUM_GPIO-1:0];
         end
         if (reg_off == `GPIO_DIR) begin
            dir_q <= req_i.pwdata[`NUM_GPIO-1:0];
         end
      end
   end

   // Pins are asynchronous to clk_i
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         sync1_q <= '0;
         sync2_q <= '0;
      end else begin
         sync1_q <= gpio_in_i;
         sync2_q <= sync1_q;
      end
   end

   always_comb begin
      rsp_o.prdata  = '0;
      rsp_o.pready  = access;
      rsp_o.pslverr = 1'b0;
      case (reg_off)
         `GPIO_OUT: rsp_o.prdata = apb_data_t'(out_q);
         `GPIO_DIR: rsp_o.prdata = apb_data_t'(dir_q);
         `GPIO_IN:  rsp_o.prdata = apb_data_t'(sync2_q);
         default:   rsp_o.pslverr = access;
      endcase
   end

   assign gpio_pads_o.out = out_q;
   assign gpio_pads_o.oe  = dir_q;

   // Access phase always follows a cycle with psel high
   a_penable_psel: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      req_i.penable |-> req_i.psel && $past(req_i.psel)
   ) else $error("GPIO penable without a setup phase");

endmodule

/* src/apb_pwm_timer.sv */
/*
 * APB PWM timer
 * One free running counter shared by four compare channels with
 * registered outputs
 */
`include "apb_periph_defines.svh"

module apb_pwm_timer (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  apb_periph_pkg::apb_req_t  req_i,
   output apb_periph_pkg::apb_rsp_t  rsp_o,
   output logic [`PWM_CH-1:0]        pwm_o
);
   import apb_periph_pkg::*;

   reg_off_t             reg_off;
   logic                 access;
   logic                 wr_en;
   logic [`PWM_CH-1:0]   cmp_hit;
   logic                 en_q;
   logic [`PWM_CW-1:0]   period_q;
   logic [`PWM_CW-1:0]   cmp_q [`PWM_CH];
   logic [`PWM_CW-1:0]   cnt_q;
   logic [`PWM_CH-1:0]   pwm_q;

   assign reg_off = req_i.paddr[`REG_OFF_MSB:`REG_OFF_LSB];
   assign access  = req_i.psel && req_i.penable;
   assign wr_en   = access && req_i.pwrite;

   assign cmp_hit = {reg_off == `PWM_CMP3, reg_off == `PWM_CMP2,
                     reg_off == `PWM_CMP1, reg_off == `PWM_CMP0};

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         en_q     <= 1'b0;
         period_q <= '0;
         for (int n = 0; n < `PWM_CH; n++) begin
            cmp_q[n] <= '0;
         end
      end else if (wr_en) begin
         if (reg_off == `PWM_CTRL) begin
            en_q <= req_i.pwdata[0];
         end
         if (reg_off == `PWM_PERIOD) begin
            period_q <= req_i.pwdata[`PWM_CW-1:0];
         end
         for (int n = 0; n < `PWM_CH; n++) begin
            if (cmp_hit[n]) begin
               cmp_q[n] <= req_i.pwdata[`PWM_CW-1:0];
            end
         end
      end
   end

   // Counts 0..period, so one PWM cycle is period+1 clocks
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cnt_q <= '0;
         pwm_q <= '0;
      end else begin
         if (!en_q || cnt_q >= period_q) begin
            cnt_q <= '0;
         end else begin
            cnt_q <= cnt_q + 1'b1;
         end
         for (int n = 0; n < `PWM_CH; n++) begin
            pwm_q[n] <= en_q && (cnt_q < cmp_q[n]);
         end
      end
   end

   assign pwm_o = pwm_q;

   always_comb begin
      rsp_o.prdata  = '0;
      rsp_o.pready  = access;
      rsp_o.pslverr = 1'b0;
      case (reg_off)
         `PWM_CTRL:   rsp_o.prdata = apb_data_t'(en_q);
         `PWM_PERIOD: rsp_o.prdata = apb_data_t'(period_q);
         `PWM_CMP0:   rsp_o.prdata = apb_data_t'(cmp_q[0]);
         `PWM_CMP1:   rsp_o.prdata = apb_data_t'(cmp_q[1]);
         `PWM_CMP2:   rsp_o.prdata = apb_data_t'(cmp_q[2]);
         `PWM_CMP3:   rsp_o.prdata = apb_data_t'(cmp_q[3]);
         default:     rsp_o.pslverr = access;
      endcase
   end

   // a period write may leave the counter above it for one cycle
   a_cnt_in_period: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      en_q && $stable(period_q) |-> cnt_q <= period_q
   ) else $error("PWM counter above period");

endmodule

/* src/apb_soc_ctrl.sv */
/*
 * APB SoC control block
 * Cluster reset release, boot and fetch enables plus a read-only ID
 */
`include "apb_periph_defines.svh"

module apb_soc_ctrl (
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   input  apb_periph_pkg::apb_req_t       req_i,
   output apb_periph_pkg::apb_rsp_t       rsp_o,
   output apb_periph_pkg::cluster_ctrl_t  cluster_ctrl_o
);
   import apb_periph_pkg::*;

   reg_off_t       reg_off;
   logic           access;
   logic           wr_en;
   cluster_ctrl_t  ctrl_q;

   assign reg_off = req_i.paddr[`REG_OFF_MSB:`REG_OFF_LSB];
   assign access  = req_i.psel && req_i.penable;
   assign wr_en   = access && req_i.pwrite;

   // Cluster stays in reset with fetch off until software releases it
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ctrl_q <= '0;
      end else if (wr_en && reg_off == `SOC_CLUSTER) begin
         ctrl_q.cluster_rstn <= req_i.pwdata[0];
         ctrl_q.boot_en      <= req_i.pwdata[1];
         ctrl_q.fetch_en     <= req_i.pwdata[2] && req_i.pwdata[0];
      end
   end

   assign cluster_ctrl_o = ctrl_q;

   always_comb begin
      rsp_o.prdata  = '0;
      rsp_o.pready  = access;
      rsp_o.pslverr = 1'b0;
      case (reg_off)
         `SOC_CLUSTER: rsp_o.prdata = apb_data_t'(ctrl_q);
         `SOC_ID:      rsp_o.prdata = `SOC_ID_VALUE;
         default:      rsp_o.pslverr = access;
      endcase
   end

   a_fetch_needs_rstn: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      cluster_ctrl_o.fetch_en |-> cluster_ctrl_o.cluster_rstn
   ) else $error("cluster fetch enabled while held in reset");

endmodule

/* src/apb_periph_subsystem.sv */
/*
 * APB peripheral subsystem
 * One APB target port decoded onto GPIO, PWM timer and SoC control
 */
`include "apb_periph_defines.svh"

module apb_periph_subsystem (
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   input  apb_periph_pkg::apb_req_t       apb_req_i,
   output apb_periph_pkg::apb_rsp_t       apb_rsp_o,
   input  logic [`NUM_GPIO-1:0]           gpio_in_i,
   output apb_periph_pkg::gpio_pads_t     gpio_pads_o,
   output logic [`PWM_CH-1:0]             pwm_o,
   output apb_periph_pkg::cluster_ctrl_t  cluster_ctrl_o
);
   import apb_periph_pkg::*;

   apb_req_t periph_req [`NUM_SLAVES];
   apb_rsp_t periph_rsp [`NUM_SLAVES];

   apb_periph_decoder i_decoder (
      .clk_i     ( clk_i      ),
      .rst_n_i   ( rst_n_i    ),
      .slv_req_i ( apb_req_i  ),
      .slv_rsp_o ( apb_rsp_o  ),
      .mst_req_o ( periph_req ),
      .mst_rsp_i ( periph_rsp )
   );

   // Window 0
   apb_gpio i_gpio (
      .clk_i       ( clk_i         ),
      .rst_n_i     ( rst_n_i       ),
      .req_i       ( periph_req[0] ),
      .rsp_o       ( periph_rsp[0] ),
      .gpio_in_i   ( gpio_in_i     ),
      .gpio_pads_o ( gpio_pads_o   )
   );

   // Window 1
   apb_pwm_timer i_pwm_timer (
      .clk_i   ( clk_i         ),
      .rst_n_i ( rst_n_i       ),
      .req_i   ( periph_req[1] ),
      .rsp_o   ( periph_rsp[1] ),
      .pwm_o   ( pwm_o         )
   );

   // Window 2
   apb_soc_ctrl i_soc_ctrl (
      .clk_i          ( clk_i          ),
      .rst_n_i        ( rst_n_i        ),
      .req_i          ( periph_req[2]  ),
      .rsp_o          ( periph_rsp[2]  ),
      .cluster_ctrl_o ( cluster_ctrl_o )
   );

endmodule

/* tb/tb_apb_periph_subsystem.sv */
/*
 * Testbench for the APB peripheral subsystem
 * Replays the golden operation list through the APB port and checks
 * read data, error responses, pads, PWM duty and cluster control
 */
`include "apb_periph_defines.svh"

module tb_apb_periph_subsystem;
   timeunit 1ns;
   timeprecision 1ps;
   import apb_periph_pkg::*;

   localparam int RST_CYCLES  = 8;
   localparam int MAX_ENTRIES = 64;
   localparam int FIELDS      = 5;

   // Golden file op codes
   localparam logic [31:0] OP_WRITE = 32'h0;
   localparam logic [31:0] OP_READ  = 32'h1;
   localparam logic [31:0] OP_PINS  = 32'h2;
   localparam logic [31:0] OP_PWM   = 32'h3;
   localparam logic [31:0] OP_CHECK = 32'h4;
   localparam logic [31:0] OP_END   = 32'hF;

   logic                 clk;
   logic                 rst_n;
   apb_req_t             apb_req;
   apb_rsp_t             apb_rsp;
   logic [`NUM_GPIO-1:0] gpio_in;
   gpio_pads_t           gpio_pads;
   logic [`PWM_CH-1:0]   pwm;
   cluster_ctrl_t        cluster_ctrl;

   logic [31:0] golden [MAX_ENTRIES*FIELDS];
   int          num_entries;
   int          cycle_cnt;
   int          cycle_limit;
   int          check_count;
   int          mismatch_count;
   int          fail_count;

   apb_periph_subsystem i_dut (
      .clk_i          ( clk          ),
      .rst_n_i        ( rst_n        ),
      .apb_req_i      ( apb_req      ),
      .apb_rsp_o      ( apb_rsp      ),
      .gpio_in_i      ( gpio_in      ),
      .gpio_pads_o    ( gpio_pads    ),
      .pwm_o          ( pwm          ),
      .cluster_ctrl_o ( cluster_ctrl )
   );

   always #5 clk = ~clk;

   task automatic print_summary();
      $display("Checks: %0d, mismatches: %0d, other errors: %0d",
               check_count, mismatch_count, fail_count);
   endtask

   // Guards against a DUT that never answers
   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
         $display("ERROR: timeout reached after %0d cycles", cycle_cnt);
         fail_count++;
         print_summary();
         $display("FAIL: see errors above");
         $finish;
      end
   end

   task automatic check_val(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
      check_count++;
      if (actual !== expected) begin
         mismatch_count++;
         $display("MISMATCH at %0t ns: %s actual=0x%08h expected=0x%08h",
                  $time, name, actual, expected);
      end
   endtask

   // One APB transfer, setup then access, sampled at the falling edge
   task automatic apb_xfer(input logic wr, input logic [31:0] addr,
                           input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
      int waits;
      @(posedge clk);
      apb_req.psel    <= 1'b1;
      apb_req.penable <= 1'b0;
      apb_req.pwrite  <= wr;
      apb_req.paddr   <= addr;
      apb_req.pwdata  <= wdata;
      @(negedge clk);
      check_val("apb_rsp_o.pready in setup", apb_rsp.pready, 1'b0);
      @(posedge clk);
      apb_req.penable <= 1'b1;
      @(negedge clk);
      waits = 0;
      while (!apb_rsp.pready) begin
         @(negedge clk);
         waits++;
      end
      rdata = apb_rsp.prdata;
      err   = apb_rsp.pslverr;
      check_val("wait states", waits, 0);
      // Completion edge
      @(posedge clk);
      apb_req.psel    <= 1'b0;
      apb_req.penable <= 1'b0;
   endtask

   task automatic run_entry(input int idx);
      logic [31:0] op;
      logic [31:0] addr;
      logic [31:0] wdata;
      logic [31:0] exp_rdata;
      logic [31:0] exp_err;
      logic [31:0] rdata;
      logic        err;
      int          highs [`PWM_CH];
      op        = golden[idx*FIELDS];
      addr      = golden[idx*FIELDS+1];
      wdata     = golden[idx*FIELDS+2];
      exp_rdata = golden[idx*FIELDS+3];
      exp_err   = golden[idx*FIELDS+4];
      case (op)
         OP_WRITE: begin
            apb_xfer(1'b1, addr, wdata, rdata, err);
            check_val($sformatf("apb_rsp_o.pslverr (write 0x%04h)", addr[15:0]),
                      err, exp_err);
         end
         OP_READ: begin
            apb_xfer(1'b0, addr, '0, rdata, err);
            check_val($sformatf("apb_rsp_o.prdata (read 0x%04h)", addr[15:0]),
                      rdata, exp_rdata);
            check_val($sformatf("apb_rsp_o.pslverr (read 0x%04h)", addr[15:0]),
                      err, exp_err);
         end
         OP_PINS: begin
            @(posedge clk);
            gpio_in <= addr[`NUM_GPIO-1:0];
            // Two synchronizer stages
            repeat (2) @(posedge clk);
         end
         OP_PWM: begin
            @(posedge clk);
            for (int n = 0; n < `PWM_CH; n++) begin
               highs[n] = 0;
            end
            repeat (addr) begin
               @(negedge clk);
               for (int n = 0; n < `PWM_CH; n++) begin
                  highs[n] += int'(pwm[n]);
               end
            end
            for (int n = 0; n < `PWM_CH; n++) begin
               check_val($sformatf("pwm_o[%0d] high cycles", n), highs[n],
                         {24'h0, exp_rdata[8*n +: 8]});
            end
         end
         OP_CHECK: begin
            @(negedge clk);
            case (addr)
               0: check_val("gpio_pads_o", gpio_pads, exp_rdata);
               1: check_val("pwm_o", {28'h0, pwm}, exp_rdata);
               2: check_val("cluster_ctrl_o", {29'h0, cluster_ctrl}, exp_rdata);
               default: begin
                  $display("ERROR: golden entry %0d selects unknown output %0d", idx, addr);
                  fail_count++;
               end
            endcase
         end
         default: begin
            $display("ERROR: golden entry %0d has unknown op code 0x%0h", idx, op);
            fail_count++;
         end
      endcase
   endtask

   initial begin
      int pwm_cycles;
      logic [31:0] op;
      clk            = 1'b0;
      rst_n          = 1'b0;
      apb_req        = '0;
      gpio_in        = '0;
      cycle_cnt      = 0;
      cycle_limit    = 0;
      check_count    = 0;
      mismatch_count = 0;
      fail_count     = 0;
      num_entries    = 0;
      pwm_cycles     = 0;

      $readmemh("tb/apb_periph_golden.txt", golden);
      while (num_entries < MAX_ENTRIES) begin
         op = golden[num_entries*FIELDS];
         if ($isunknown(op)) begin
            $display("ERROR: golden file ends without an end marker");
            fail_count++;
            break;
         end
         if (op == OP_END) begin
            break;
         end
         if (op == OP_PWM) begin
            pwm_cycles += int'(golden[num_entries*FIELDS+1]);
         end
         num_entries++;
      end
      cycle_limit = num_entries * 40 + RST_CYCLES + pwm_cycles;

      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;

      for (int i = 0; i < num_entries; i++) begin
         run_entry(i);
      end
      repeat (2) @(posedge clk);

      print_summary();
      if (mismatch_count == 0 && fail_count == 0 && num_entries > 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule

/* tb/apb_periph_golden.txt */
// op addr wdata exp_rdata exp_pslverr, all hex
// op 0 write, 1 read, 2 drive pins (addr = pin value), 3 count PWM highs
// (addr = cycles, exp_rdata = one count byte per channel), 4 check output
// (addr 0 pads, 1 pwm, 2 cluster), F end of list
4 0 0 0 0
4 1 0 0 0
4 2 0 0 0
1 2004 0 50C00A01 0
0 0000 1234A5C3 0 0
1 0000 0 0000A5C3 0
0 0004 000000FF 0 0
1 0004 0 000000FF 0
4 0 0 A5C300FF 0
0 0008 FFFF 0 0
1 0000 0 0000A5C3 0
2 5A3C 0 0 0
1 0008 0 00005A3C 0
1 000C 0 0 1
0 1004 9 0 0
1 1004 0 9 0
0 1008 0 0 0
0 100C 3 0 0
0 1010 7 0 0
0 1014 A 0 0
1 100C 0 3 0
1 1014 0 A 0
0 1018 1 0 1
0 1000 1 0 0
1 1000 0 1 0
3 A 0 0A070300 0
0 2000 6 0 0
1 2000 0 2 0
4 2 0 2 0
0 2000 7 0 0
4 2 0 7 0
1 2008 0 0 1
1 3000 0 0 1
0 F000 DEADBEEF 0 1
1 F004 0 0 1
F 0 0 0 0

/* apb_periph_subsystem.f */
+incdir+src
src/apb_periph_pkg.sv
src/apb_periph_decoder.sv
src/apb_gpio.sv
src/apb_pwm_timer.sv
src/apb_soc_ctrl.sv
src/apb_periph_subsystem.sv
tb/tb_apb_periph_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the APB peripheral subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
   --top-module tb_apb_periph_subsystem \
   -f apb_periph_subsystem.f \
   && ./obj_dir/Vtb_apb_periph_subsystem > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }

cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1
exit 0
